// File: shader_pkg.sv
package shader_pkg;

    // vertex coordinates are signed integers
    localparam int COORD_W = 10;

    // one bit more than a coordinate, enough for the difference of two
    localparam int EDGE_W = 11;

    // products of two edge components and their difference
    localparam int CROSS_W = 23;

    // unsigned square of one normal component
    localparam int SQ_W = 46;

    // sum of the three squares, also holds 32 * nz^2
    localparam int MAG_W = 48;

    // quotient of 32 * cos^2, never above 32
    localparam int Q_W = 6;

    localparam int IDX_MAX = 16;

    localparam int COLOR_W = 8;

    // back-facing triangles get full white
    localparam logic [COLOR_W-1:0] CULL_COLOR = 8'hFF;

    // grey level for 16 * cos^2 rounded, top entry clamped to 254
    localparam logic [COLOR_W-1:0] SHADE_LUT [0:IDX_MAX] = '{
        8'd0,   8'd16,  8'd32,  8'd48,
        8'd64,  8'd80,  8'd96,  8'd112,
        8'd128, 8'd144, 8'd160, 8'd176,
        8'd192, 8'd208, 8'd224, 8'd240,
        8'd254
    };

    typedef struct packed {
        logic signed [COORD_W-1:0] x;
        logic signed [COORD_W-1:0] y;
        logic signed [COORD_W-1:0] z;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        logic signed [CROSS_W-1:0] nx;
        logic signed [CROSS_W-1:0] ny;
        logic signed [CROSS_W-1:0] nz;
    } normal_t;

    // divider operands plus the flags that bypass it
    typedef struct packed {
        logic [MAG_W-1:0] numerator;
        logic [MAG_W-1:0] denominator;
        logic             culled;
        logic             dark;
    } div_req_t;

    typedef struct packed {
        logic [Q_W-1:0] quotient;
        logic           culled;
        logic           dark;
    } shade_req_t;

endpackage

// File: edge_cross.sv
`timescale 1ns/1ps

module edge_cross (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  valid_in,
    input  shader_pkg::triangle_t tri_in,
    output logic                  valid_out,
    output shader_pkg::normal_t   normal_out
);

    // first edge v1 - v0 is (d, e, f)
    logic signed [shader_pkg::EDGE_W-1:0] d;
    logic signed [shader_pkg::EDGE_W-1:0] e;
    logic signed [shader_pkg::EDGE_W-1:0] f;

    // second edge v2 - v0 is (g, h, i)
    logic signed [shader_pkg::EDGE_W-1:0] g;
    logic signed [shader_pkg::EDGE_W-1:0] h;
    logic signed [shader_pkg::EDGE_W-1:0] i;

    logic valid_s1;

    // stage 1, edge vectors from vertex 0
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= valid_in;
        end

        // operands are sign extended to EDGE_W before the subtraction
        d <= tri_in.v1.x - tri_in.v0.x;
        e <= tri_in.v1.y - tri_in.v0.y;
        f <= tri_in.v1.z - tri_in.v0.z;
        g <= tri_in.v2.x - tri_in.v0.x;
        h <= tri_in.v2.y - tri_in.v0.y;
        i <= tri_in.v2.z - tri_in.v0.z;
    end

    // stage 2, cross product of the two edges
    // products are formed at CROSS_W, so the differences cannot wrap
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_s1;
        end

        normal_out.nx <= e * i - f * h;
        normal_out.ny <= f * g - d * i;
        normal_out.nz <= d * h - e * g;
    end

endmodule

// File: normal_magnitude.sv
`timescale 1ns/1ps

module normal_magnitude (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 valid_in,
    input  shader_pkg::normal_t  normal_in,
    output logic                 valid_out,
    output shader_pkg::div_req_t req_out
);

    logic [shader_pkg::SQ_W-1:0] sq_x;
    logic [shader_pkg::SQ_W-1:0] sq_y;
    logic [shader_pkg::SQ_W-1:0] sq_z;
    logic                        nz_neg;
    logic                        valid_s1;

    logic [shader_pkg::MAG_W-1:0] mag_sum;

    // stage 1, squares of the normal components
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= valid_in;
        end

        sq_x   <= normal_in.nx * normal_in.nx;
        sq_y   <= normal_in.ny * normal_in.ny;
        sq_z   <= normal_in.nz * normal_in.nz;
        nz_neg <= normal_in.nz[shader_pkg::CROSS_W-1];
    end

    // squared magnitude of the normal, light has unit length
    assign mag_sum = sq_x + sq_y + sq_z;

    // stage 2, divider operands and the bypass flags
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_s1;
        end

        // 32 * nz^2 so the quotient carries five fraction bits of cos^2
        req_out.numerator   <= sq_z << (shader_pkg::Q_W - 1);
        req_out.denominator <= mag_sum;
        // normal points away from the light
        req_out.culled      <= nz_neg;
        req_out.dark        <= (mag_sum == '0);
    end

endmodule

// File: cos_divider.sv
`timescale 1ns/1ps

module cos_divider (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   valid_in,
    input  shader_pkg::div_req_t   req_in,
    output logic                   valid_out,
    output shader_pkg::shade_req_t shade_out
);

    // index 0 is the input, index k+1 is the register after stage k
    logic                 valid_s [0:shader_pkg::Q_W];
    shader_pkg::div_req_t st      [0:shader_pkg::Q_W];
    logic [shader_pkg::Q_W-1:0] quot_s [0:shader_pkg::Q_W];

    assign valid_s[0] = valid_in;
    assign st[0]      = req_in;
    assign quot_s[0]  = '0;

    // the numerator field of st[] carries the partial remainder
    for (genvar k = 0; k < shader_pkg::Q_W; k++) begin : g_stage
        logic [shader_pkg::MAG_W+shader_pkg::Q_W-1:0] shifted_den;
        logic [shader_pkg::MAG_W+shader_pkg::Q_W-1:0] rem_wide;
        logic                                         take;

        // denominator aligned to quotient bit Q_W-1-k
        assign shifted_den = {{shader_pkg::Q_W{1'b0}}, st[k].denominator}
                             << (shader_pkg::Q_W - 1 - k);
        assign rem_wide    = {{shader_pkg::Q_W{1'b0}}, st[k].numerator};
        assign take        = (rem_wide >= shifted_den);

        always_ff @(posedge clk_in) begin
            if (rst_in) begin
                valid_s[k+1] <= 1'b0;
            end else begin
                valid_s[k+1] <= valid_s[k];
            end

            // when take is set the shifted denominator fits in MAG_W bits
            if (take) begin
                st[k+1].numerator <= st[k].numerator
                                     - shifted_den[shader_pkg::MAG_W-1:0];
            end else begin
                st[k+1].numerator <= st[k].numerator;
            end
            st[k+1].denominator <= st[k].denominator;
            st[k+1].culled      <= st[k].culled;
            st[k+1].dark        <= st[k].dark;

            quot_s[k+1]                         <= quot_s[k];
            quot_s[k+1][shader_pkg::Q_W-1-k]    <= take;
        end
    end

    // floor(32 * nz^2 / mag), at most 32 since nz^2 <= mag
    assign valid_out          = valid_s[shader_pkg::Q_W];
    assign shade_out.quotient = quot_s[shader_pkg::Q_W];
    assign shade_out.culled   = st[shader_pkg::Q_W].culled;
    assign shade_out.dark     = st[shader_pkg::Q_W].dark;

endmodule

// File: shade_lookup.sv
`timescale 1ns/1ps

module shade_lookup (
    input  logic                             clk_in,
    input  logic                             rst_in,
    input  logic                             valid_in,
    input  shader_pkg::shade_req_t           shade_in,
    output logic                             valid_out,
    output logic [shader_pkg::COLOR_W-1:0]   color_out
);

    logic [shader_pkg::Q_W-1:0] q_plus;
    logic [shader_pkg::Q_W-2:0] idx_r;
    logic                       culled_r;
    logic                       dark_r;
    logic                       valid_r;

    // quotient is 32 * cos^2, so (q + 1) / 2 rounds 16 * cos^2 half up
    assign q_plus = shade_in.quotient + 1'b1;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= valid_in;
        end

        idx_r    <= q_plus[shader_pkg::Q_W-1:1];
        culled_r <= shade_in.culled;
        dark_r   <= shade_in.dark;
    end

    // colour holds its last value between strobes
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
            color_out <= '0;
        end else begin
            valid_out <= valid_r;
            if (valid_r) begin
                if (culled_r) begin
                    color_out <= shader_pkg::CULL_COLOR;
                end else if (dark_r) begin
                    color_out <= shader_pkg::SHADE_LUT[0];
                end else begin
                    color_out <= shader_pkg::SHADE_LUT[idx_r];
                end
            end
        end
    end

endmodule

// File: pixel_shader.sv
`timescale 1ns/1ps

module pixel_shader (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           valid_in,
    input  shader_pkg::triangle_t          tri_in,
    output logic                           valid_out,
    output logic [shader_pkg::COLOR_W-1:0] color_out
);

    logic                   normal_valid;
    shader_pkg::normal_t    normal;

    logic                   req_valid;
    shader_pkg::div_req_t   req;

    logic                   shade_valid;
    shader_pkg::shade_req_t shade;

    // 2 cycles, edges then cross product
    edge_cross u_edge_cross (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .valid_in   (valid_in),
        .tri_in     (tri_in),
        .valid_out  (normal_valid),
        .normal_out (normal)
    );

    // 2 cycles, squares and magnitude
    normal_magnitude u_normal_magnitude (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (normal_valid),
        .normal_in (normal),
        .valid_out (req_valid),
        .req_out   (req)
    );

    // 6 cycles, one quotient bit each
    cos_divider u_cos_divider (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (req_valid),
        .req_in    (req),
        .valid_out (shade_valid),
        .shade_out (shade)
    );

    // 2 cycles, round then table lookup
    shade_lookup u_shade_lookup (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (shade_valid),
        .shade_in  (shade),
        .valid_out (valid_out),
        .color_out (color_out)
    );

endmodule

// File: tb_pixel_shader.sv
`timescale 1ns/1ps

module tb_pixel_shader;

    logic                           clk_in;
    logic                           rst_in;
    logic                           valid_in;
    shader_pkg::triangle_t          tri_in;
    logic                           valid_out;
    logic [shader_pkg::COLOR_W-1:0] color_out;

    // tests as loaded from the file
    string                          test_name [$];
    shader_pkg::triangle_t          test_tri  [$];
    logic [shader_pkg::COLOR_W-1:0] test_exp  [$];

    // results still in flight in entry order
    string                          pend_name  [$];
    logic [shader_pkg::COLOR_W-1:0] pend_color [$];
    int                             pend_cycle [$];

    int cycle;
    int limit;
    int seed;

    pixel_shader dut (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (valid_in),
        .tri_in    (tri_in),
        .valid_out (valid_out),
        .color_out (color_out)
    );

    initial begin
        clk_in = 1'b0;
        forever begin
            #2 clk_in = ~clk_in;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_tests();
        int                    fd;
        int                    n;
        int                    c [0:8];
        int                    col;
        string                 line;
        string                 name;
        shader_pkg::triangle_t t;
        fd = $fopen("shader_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open shader_tests.txt");
            $display(">>> FAIL");
            $fatal(1, "missing tests file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip comments and blank lines
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %h", name,
                        c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8], col);
            if (n != 11) begin
                $display("malformed line in tests file: %s", line);
                $display(">>> FAIL");
                $fatal(1, "bad tests file");
            end
            t.v0.x = c[0];
            t.v0.y = c[1];
            t.v0.z = c[2];
            t.v1.x = c[3];
            t.v1.y = c[4];
            t.v1.z = c[5];
            t.v2.x = c[6];
            t.v2.y = c[7];
            t.v2.z = c[8];
            test_name.push_back(name);
            test_tri.push_back(t);
            test_exp.push_back(col[shader_pkg::COLOR_W-1:0]);
        end
        $fclose(fd);
    endtask

    // cycle counter and watchdog
    always @(posedge clk_in) begin
        cycle <= cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("timeout, results did not arrive within %0d cycles", limit);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    // results are checked at the falling edge
    always @(negedge clk_in) begin
        string                          name;
        logic [shader_pkg::COLOR_W-1:0] expected;
        int                             entry;
        if (valid_out) begin
            if (pend_color.size() == 0) begin
                $display("valid_out pulsed with no triangle outstanding");
                $display(">>> FAIL");
                $fatal(1, "unexpected result");
            end else begin
                name     = pend_name.pop_front();
                expected = pend_color.pop_front();
                entry    = pend_cycle.pop_front();
                check_value(name, expected, color_out);
                check_value({name, "_latency"}, 12, cycle - entry);
            end
        end
    end

    initial begin
        int gap;
        cycle         = 0;
        limit         = 0;
        seed          = 71857;
        rst_in        = 1'b1;
        valid_in      = 1'b0;
        tri_in        = '0;

        load_tests();
        if (test_tri.size() == 0) begin
            $display("no tests found in shader_tests.txt");
            $display(">>> FAIL");
            $fatal(1, "empty tests file");
        end
        limit = 10 + 2 * test_tri.size() + 12 + 40;

        repeat (10) @(posedge clk_in);
        rst_in <= 1'b0;

        // idle outputs after reset
        repeat (5) begin
            @(negedge clk_in);
            check_value("idle_valid", 0, valid_out);
            check_value("idle_color", 0, color_out);
        end

        @(posedge clk_in);
        // first half back to back and the rest with random gaps
        for (int k = 0; k < test_tri.size(); k++) begin
            if (k >= test_tri.size() / 2) begin
                gap = {$random(seed)} % 2;
                repeat (gap) begin
                    valid_in <= 1'b0;
                    @(posedge clk_in);
                end
            end
            valid_in <= 1'b1;
            tri_in   <= test_tri[k];
            pend_name.push_back(test_name[k]);
            pend_color.push_back(test_exp[k]);
            pend_cycle.push_back(cycle + 1);
            @(posedge clk_in);
        end
        valid_in <= 1'b0;

        while (pend_color.size() > 0) begin
            @(negedge clk_in);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: shader_tests.txt
# name  v0x v0y v0z  v1x v1y v1z  v2x v2y v2z  expected_colour_hex
# coordinates are signed decimal, colour is the 8-bit grey level
flat_unit 0 0 0 1 0 0 0 1 0 fe
flat_big 0 0 0 100 0 0 0 50 0 fe
flat_offset 10 20 30 15 20 30 10 27 30 fe
back_unit 0 0 0 0 1 0 1 0 0 ff
slope_45 0 0 0 1 0 0 0 1 1 80
slope_45_back 0 0 0 0 1 1 1 0 0 ff
oblique_2_1 0 0 0 1 0 0 0 2 1 d0
oblique_1_2 0 0 0 1 0 0 0 1 2 30
oblique_3_1 0 0 0 1 0 0 0 3 1 e0
oblique_1_3 0 0 0 1 0 0 0 1 3 20
oblique_3_2 0 0 0 1 0 0 0 3 2 b0
oblique_2_3 0 0 0 1 0 0 0 2 3 50
oblique_1_4 0 0 0 1 0 0 0 1 4 10
oblique_1_5 0 0 0 1 0 0 0 1 5 10
oblique_1_6 0 0 0 1 0 0 0 1 6 00
oblique_5_1 0 0 0 1 0 0 0 5 1 f0
oblique_7_1 0 0 0 1 0 0 0 7 1 fe
oblique_4_1 0 0 0 1 0 0 0 4 1 f0
oblique_3_4 0 0 0 1 0 0 0 3 4 60
oblique_4_3 0 0 0 1 0 0 0 4 3 a0
oblique_1_10 0 0 0 1 0 0 0 1 10 00
oblique_5_12 0 0 0 1 0 0 0 5 12 20
oblique_12_5 0 0 0 1 0 0 0 12 5 e0
three_axis 0 0 0 2 1 0 0 1 1 70
general_lit 0 0 0 4 5 6 1 2 3 30
general_back 0 0 0 1 2 3 4 5 6 ff
offset_lit -100 50 7 -99 50 7 -100 53 11 60
offset_back -100 50 7 -100 53 11 -99 50 7 ff
neg_edges 0 0 0 -1 0 0 0 -2 1 d0
collinear 0 0 0 1 2 3 2 4 6 00
same_point 5 5 5 5 5 5 5 5 5 00
repeat_v1 3 4 5 3 4 5 7 1 2 00
edge_on_y 0 0 0 1 0 0 0 0 1 00
edge_on_x 0 0 0 0 1 0 0 0 1 00
extreme_flat -512 -512 0 511 -512 0 -512 511 0 fe
extreme_back -512 -512 0 -512 511 0 511 -512 0 ff
extreme_45 -512 -512 -512 511 -512 -512 -512 511 511 80
extreme_pos 511 511 511 -512 511 511 511 -512 511 fe
extreme_diag -512 -512 511 511 -512 -512 511 511 511 50
extreme_diag_back -512 -512 511 511 511 511 511 -512 -512 ff

// File: vlog.f
shader_pkg.sv
edge_cross.sv
normal_magnitude.sv
cos_divider.sv
shade_lookup.sv
pixel_shader.sv
tb_pixel_shader.sv
